// File: source/frv_core_pkg.sv
/*
 Data path widths and register address types shared by every stage.
 The word width is fixed at 32 bits and is not meant to vary.
*/
package frv_core_pkg;

    // Data path
    // ----------------------------------------
    localparam int XLEN = 32;                  // Data word width

    typedef logic [XLEN-1:0] xlen_t;           // One data word

    // Register file addressing
    // ----------------------------------------
    typedef logic [4:0] reg_addr_t;            // x0..x31, x0 reads zero

endpackage : frv_core_pkg

// File: source/frv_isa_pkg.sv
/*
 Custom 32-bit instruction encoding with seven operations.
 Opcode values 7 to 15 are undefined and retire without a register write.
 Register and immediate forms share the opcode, rd and rs1 fields.
*/
package frv_isa_pkg;
    import frv_core_pkg::*;

    localparam int IMM_W = 18;                 // ADDI immediate, sign-extended

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,                        // rd = rs1 + rs2
        OP_SUB  = 4'h1,                        // rd = rs1 - rs2
        OP_XOR  = 4'h2,                        // rd = rs1 ^ rs2
        OP_ADDI = 4'h3,                        // rd = rs1 + imm
        OP_ADD3 = 4'h4,                        // rd = rs1 + rs2 + rs3
        OP_MUL  = 4'h5,                        // rd = low word of rs1 * rs2
        OP_MULW = 4'h6                         // rd pair = 64-bit rs1 * rs2
    } opcode_t;

    // Register form
    typedef struct packed {
        opcode_t   opcode;                     // [31:28]
        reg_addr_t rd;                         // [27:23]
        reg_addr_t rs1;                        // [22:18]
        reg_addr_t rs2;                        // [17:13]
        reg_addr_t rs3;                        // [12:8]
        logic [7:0] zero;                      // Must be zero
    } instr_r_t;

    // Immediate form
    typedef struct packed {
        opcode_t          opcode;
        reg_addr_t        rd;
        reg_addr_t        rs1;
        logic [IMM_W-1:0] imm;                 // [17:0]
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    function automatic logic op_known(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_XOR, OP_ADDI, OP_ADD3, OP_MUL, OP_MULW};
    endfunction

    // Product only ready in s3
    function automatic logic op_is_mul(opcode_t op);
        return (op == OP_MUL) || (op == OP_MULW);
    endfunction

endpackage : frv_isa_pkg

// File: source/frv_fwd_if.sv
/*
 Result that a later stage offers to the hazard unit.
 wdata_hi only carries meaning while wide is high.
*/
`timescale 1ns/10ps

interface frv_fwd_if import frv_core_pkg::*; ();

    logic      valid;                          // Stage holds a writing instruction
    reg_addr_t rd;                             // Destination, even for a wide pair
    logic      wide;                           // Register pair write
    xlen_t     wdata;                          // Low word or single result
    xlen_t     wdata_hi;                       // High word of the pair

    modport producer (
        output valid, rd, wide, wdata, wdata_hi
    );

    modport consumer (
        input  valid, rd, wide, wdata, wdata_hi
    );

endinterface : frv_fwd_if

// File: source/frv_gprs.sv
/*
 31 general registers with three combinational reads and one wide write.
 x0 reads zero and ignores writes. A wide write must name an even rd.
 A read in the cycle of a write returns the old value.
*/
`timescale 1ns/10ps

module frv_gprs import frv_core_pkg::*; (
    input  logic      g_clk,
    input  logic      arst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rs3_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    output xlen_t     rs3_data,
    input  logic      rd_wen,                  // Write this cycle
    input  logic      rd_wide,                 // Write the pair rd, rd|1
    input  reg_addr_t rd_addr,
    input  xlen_t     rd_wdata,                // Low word
    input  xlen_t     rd_wdata_hi              // High word, wide only
);

    xlen_t     regs [1:31];                    // No storage for x0
    reg_addr_t lo_addr;
    reg_addr_t hi_addr;

    assign lo_addr = {rd_addr[4:1], 1'b0};     // Even half of the pair
    assign hi_addr = {rd_addr[4:1], 1'b1};     // Odd half, never x0

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen) begin
            if (rd_wide) begin
                if (lo_addr != '0) begin
                    regs[lo_addr] <= rd_wdata;         // Pair at x0 keeps only x1
                end
                regs[hi_addr] <= rd_wdata_hi;
            end else if (rd_addr != '0) begin
                regs[rd_addr] <= rd_wdata;
            end
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs3_data = (rs3_addr == '0) ? '0 : regs[rs3_addr];

    // Decode forces the pair destination even
    a_wide_even : assert property (@(posedge g_clk) disable iff (!arst_n)
        rd_wen && rd_wide |-> !rd_addr[0]);

endmodule : frv_gprs

// File: source/frv_hazard_unit.sv
/*
 Operand forwarding for the three s1 sources, nearest stage first.
 A source hits the odd half of a wide pair in flight as well.
 A hit on a multiply still in s2 bubbles s1 for one cycle.
*/
`timescale 1ns/10ps

module frv_hazard_unit import frv_core_pkg::*; (
    input  logic      s1_valid,
    input  reg_addr_t s1_rs1_addr,
    input  reg_addr_t s1_rs2_addr,
    input  reg_addr_t s1_rs3_addr,
    input  xlen_t     gpr_rs1_data,            // Register file values
    input  xlen_t     gpr_rs2_data,
    input  xlen_t     gpr_rs3_data,
    frv_fwd_if.consumer fwd_s2,
    frv_fwd_if.consumer fwd_s3,
    frv_fwd_if.consumer fwd_s4,
    input  logic      s2_late,                 // s2 result not yet known
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    output xlen_t     rs3_data,
    output logic      s1_bubble
);

    reg_addr_t  src_addr [3];
    xlen_t      gpr_data [3];
    xlen_t      fwd_data [3];
    logic [2:0] s2_hit;                        // Per source hit on s2

    // Same pair, and either the same register or the odd half of a wide write
    function automatic logic hits(reg_addr_t a, logic f_valid, reg_addr_t f_rd,
                                  logic f_wide);
        return f_valid && (a != '0) && (a[4:1] == f_rd[4:1]) &&
               ((a[0] == f_rd[0]) || (a[0] && !f_rd[0] && f_wide));
    endfunction

    assign src_addr = '{s1_rs1_addr, s1_rs2_addr, s1_rs3_addr};
    assign gpr_data = '{gpr_rs1_data, gpr_rs2_data, gpr_rs3_data};

    // Forwarding muxes
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            s2_hit[i] = hits(src_addr[i], fwd_s2.valid, fwd_s2.rd, fwd_s2.wide);
            if (s2_hit[i]) begin
                fwd_data[i] = (src_addr[i][0] && fwd_s2.wide) ? fwd_s2.wdata_hi
                                                               : fwd_s2.wdata;
            end else if (hits(src_addr[i], fwd_s3.valid, fwd_s3.rd, fwd_s3.wide)) begin
                fwd_data[i] = (src_addr[i][0] && fwd_s3.wide) ? fwd_s3.wdata_hi
                                                               : fwd_s3.wdata;
            end else if (hits(src_addr[i], fwd_s4.valid, fwd_s4.rd, fwd_s4.wide)) begin
                fwd_data[i] = (src_addr[i][0] && fwd_s4.wide) ? fwd_s4.wdata_hi
                                                               : fwd_s4.wdata;  // Write-through
            end else begin
                fwd_data[i] = gpr_data[i];
            end
        end
    end

    assign rs1_data = fwd_data[0];
    assign rs2_data = fwd_data[1];
    assign rs3_data = fwd_data[2];

    // Bubble decision
    // ----------------------------------------
    assign s1_bubble = s1_valid && s2_late && (|s2_hit);   // Product lands in s3 next cycle

endmodule : frv_hazard_unit

// File: source/frv_pipeline_decode.sv
/*
 s1 holds the accepted word and selects operands through the forwarding muxes.
 On a bubble s1 keeps its word and s2 receives an empty slot.
 The source must hold instr_valid and instr_word steady while busy.
*/
`timescale 1ns/10ps

module frv_pipeline_decode import frv_core_pkg::*, frv_isa_pkg::*; (
    input  logic      g_clk,
    input  logic      arst_n,
    input  logic      instr_valid,
    input  instr_t    instr_word,
    output logic      instr_busy,              // s1 must bubble
    output reg_addr_t s1_rs1_addr,
    output reg_addr_t s1_rs2_addr,
    output reg_addr_t s1_rs3_addr,
    output logic      s1_valid,
    input  xlen_t     rs1_data,                // Forwarded operands
    input  xlen_t     rs2_data,
    input  xlen_t     rs3_data,
    input  logic      s1_bubble,
    output logic      s2_valid,
    output opcode_t   s2_op,
    output reg_addr_t s2_rd,
    output xlen_t     s2_opr_a,
    output xlen_t     s2_opr_b,
    output xlen_t     s2_opr_c
);

    instr_t s1_word;
    opcode_t s1_op;
    xlen_t  s1_imm;

    assign instr_busy = s1_bubble;             // Accept whenever s1 can move

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s1_word  <= '0;
        end else if (!s1_bubble) begin
            s1_valid <= instr_valid;
            if (instr_valid) begin
                s1_word <= instr_word;
            end
        end
    end

    assign s1_op  = s1_word.r.opcode;
    assign s1_imm = {{(XLEN-IMM_W){s1_word.i.imm[IMM_W-1]}}, s1_word.i.imm};

    // Unused source fields read x0 so they never hit
    assign s1_rs1_addr = s1_word.r.rs1;
    assign s1_rs2_addr = (s1_op == OP_ADDI) ? '0 : s1_word.r.rs2;   // Immediate bits
    assign s1_rs3_addr = (s1_op == OP_ADD3) ? s1_word.r.rs3 : '0;

    // s2 register
    // ----------------------------------------
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
            s2_op    <= OP_ADD;
            s2_rd    <= '0;
            s2_opr_a <= '0;
            s2_opr_b <= '0;
            s2_opr_c <= '0;
        end else begin
            s2_valid <= s1_valid && !s1_bubble;        // Empty slot on a bubble
            s2_op    <= s1_op;
            s2_rd    <= (s1_op == OP_MULW) ? {s1_word.r.rd[4:1], 1'b0} : s1_word.r.rd;
            s2_opr_a <= rs1_data;
            s2_opr_b <= (s1_op == OP_ADDI) ? s1_imm : rs2_data;
            s2_opr_c <= rs3_data;
        end
    end

    // A late multiply leaves s2 after one cycle
    a_bubble_once : assert property (@(posedge g_clk) disable iff (!arst_n)
        s1_bubble |=> !s1_bubble);

endmodule : frv_pipeline_decode

// File: source/frv_pipeline_execute.sv
/*
 s2 ALU for the add, subtract and XOR family.
 Multiplies pass through and are offered with s2_late high.
*/
`timescale 1ns/10ps

module frv_pipeline_execute import frv_core_pkg::*, frv_isa_pkg::*; (
    input  logic      g_clk,
    input  logic      arst_n,
    input  logic      s2_valid,
    input  opcode_t   s2_op,
    input  reg_addr_t s2_rd,
    input  xlen_t     s2_opr_a,
    input  xlen_t     s2_opr_b,
    input  xlen_t     s2_opr_c,
    frv_fwd_if.producer fwd_s2,
    output logic      s2_late,                 // Multiply, product not yet known
    output logic      s3_valid,
    output opcode_t   s3_op,
    output reg_addr_t s3_rd,
    output xlen_t     s3_opr_a,
    output xlen_t     s3_opr_b,
    output xlen_t     s3_alu_res
);

    xlen_t alu_res;

    always_comb begin
        case (s2_op)
            OP_ADD, OP_ADDI: alu_res = s2_opr_a + s2_opr_b;   // B is the immediate for ADDI
            OP_SUB:          alu_res = s2_opr_a - s2_opr_b;
            OP_XOR:          alu_res = s2_opr_a ^ s2_opr_b;
            OP_ADD3:         alu_res = s2_opr_a + s2_opr_b + s2_opr_c;
            default:         alu_res = '0;                    // Multiply or undefined
        endcase
    end

    assign s2_late = s2_valid && op_is_mul(s2_op);

    assign fwd_s2.valid    = s2_valid && op_known(s2_op);
    assign fwd_s2.rd       = s2_rd;
    assign fwd_s2.wide     = (s2_op == OP_MULW);
    assign fwd_s2.wdata    = alu_res;
    assign fwd_s2.wdata_hi = '0;               // Wide only from multiply, bubbles anyway

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s3_valid   <= 1'b0;
            s3_op      <= OP_ADD;
            s3_rd      <= '0;
            s3_opr_a   <= '0;
            s3_opr_b   <= '0;
            s3_alu_res <= '0;
        end else begin
            s3_valid   <= s2_valid;
            s3_op      <= s2_op;
            s3_rd      <= s2_rd;
            s3_opr_a   <= s2_opr_a;            // Multiplier inputs
            s3_opr_b   <= s2_opr_b;
            s3_alu_res <= alu_res;
        end
    end

endmodule : frv_pipeline_execute

// File: source/frv_pipeline_multiply.sv
/*
 s3 unsigned 32x32 multiplier and the s4 writeback register.
 Undefined opcodes reach s4 with rd x0, so they retire without a write.
*/
`timescale 1ns/10ps

module frv_pipeline_multiply import frv_core_pkg::*, frv_isa_pkg::*; (
    input  logic      g_clk,
    input  logic      arst_n,
    input  logic      s3_valid,
    input  opcode_t   s3_op,
    input  reg_addr_t s3_rd,
    input  xlen_t     s3_opr_a,
    input  xlen_t     s3_opr_b,
    input  xlen_t     s3_alu_res,
    frv_fwd_if.producer fwd_s3,
    frv_fwd_if.producer fwd_s4
);

    logic [2*XLEN-1:0] s3_prod;
    logic              s3_known;
    logic              s3_wide;
    xlen_t             s3_lo;

    logic      s4_valid;
    reg_addr_t s4_rd;
    logic      s4_wide;
    xlen_t     s4_wdata;
    xlen_t     s4_wdata_hi;

    assign s3_prod  = (2*XLEN)'(s3_opr_a) * (2*XLEN)'(s3_opr_b);
    assign s3_known = op_known(s3_op);
    assign s3_wide  = (s3_op == OP_MULW);
    assign s3_lo    = op_is_mul(s3_op) ? s3_prod[XLEN-1:0] : s3_alu_res;

    assign fwd_s3.valid    = s3_valid && s3_known;
    assign fwd_s3.rd       = s3_rd;
    assign fwd_s3.wide     = s3_wide;
    assign fwd_s3.wdata    = s3_lo;
    assign fwd_s3.wdata_hi = s3_prod[2*XLEN-1:XLEN];

    // s4 writeback register
    // ----------------------------------------
    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            s4_valid    <= 1'b0;
            s4_rd       <= '0;
            s4_wide     <= 1'b0;
            s4_wdata    <= '0;
            s4_wdata_hi <= '0;
        end else begin
            s4_valid    <= s3_valid;           // Retires, defined or not
            s4_rd       <= s3_known ? s3_rd : '0;      // x0 drops the write
            s4_wide     <= s3_known && s3_wide;
            s4_wdata    <= s3_lo;
            s4_wdata_hi <= s3_prod[2*XLEN-1:XLEN];
        end
    end

    assign fwd_s4.valid    = s4_valid;
    assign fwd_s4.rd       = s4_rd;
    assign fwd_s4.wide     = s4_wide;
    assign fwd_s4.wdata    = s4_wdata;
    assign fwd_s4.wdata_hi = s4_wdata_hi;

endmodule : frv_pipeline_multiply

// File: source/frv_pipeline.sv
/*
 Integer pipeline from accepted word to writeback, valid/busy at the input.
 An instruction is accepted on an edge with instr_valid high and instr_busy low.
 The retire trace follows the register file write in the same cycle.
*/
`timescale 1ns/10ps

module frv_pipeline import frv_core_pkg::*, frv_isa_pkg::*; (
    input  logic        g_clk,
    input  logic        arst_n,
    input  logic        instr_valid,
    input  logic [31:0] instr_word,
    output logic        instr_busy,
    output logic        trs_valid,             // Instruction retired
    output reg_addr_t   trs_rd,                // x0 for undefined opcodes
    output logic        trs_wide,
    output xlen_t       trs_wdata,
    output xlen_t       trs_wdata_hi
);

    reg_addr_t s1_rs1_addr, s1_rs2_addr, s1_rs3_addr;
    logic      s1_valid;
    logic      s1_bubble;
    xlen_t     gpr_rs1_data, gpr_rs2_data, gpr_rs3_data;
    xlen_t     rs1_data, rs2_data, rs3_data;   // After forwarding

    logic      s2_valid, s2_late;
    opcode_t   s2_op;
    reg_addr_t s2_rd;
    xlen_t     s2_opr_a, s2_opr_b, s2_opr_c;

    logic      s3_valid;
    opcode_t   s3_op;
    reg_addr_t s3_rd;
    xlen_t     s3_opr_a, s3_opr_b, s3_alu_res;

    frv_fwd_if fwd_s2 ();
    frv_fwd_if fwd_s3 ();
    frv_fwd_if fwd_s4 ();                      // Also the writeback bundle

    frv_pipeline_decode i_decode (
        .g_clk, .arst_n, .instr_valid,
        .instr_word (instr_t'(instr_word)),
        .instr_busy,
        .s1_rs1_addr, .s1_rs2_addr, .s1_rs3_addr, .s1_valid,
        .rs1_data, .rs2_data, .rs3_data, .s1_bubble,
        .s2_valid, .s2_op, .s2_rd, .s2_opr_a, .s2_opr_b, .s2_opr_c
    );

    frv_hazard_unit i_hazard (
        .s1_valid, .s1_rs1_addr, .s1_rs2_addr, .s1_rs3_addr,
        .gpr_rs1_data, .gpr_rs2_data, .gpr_rs3_data,
        .fwd_s2 (fwd_s2.consumer),
        .fwd_s3 (fwd_s3.consumer),
        .fwd_s4 (fwd_s4.consumer),
        .s2_late, .rs1_data, .rs2_data, .rs3_data, .s1_bubble
    );

    frv_pipeline_execute i_execute (
        .g_clk, .arst_n,
        .s2_valid, .s2_op, .s2_rd, .s2_opr_a, .s2_opr_b, .s2_opr_c,
        .fwd_s2 (fwd_s2.producer),
        .s2_late,
        .s3_valid, .s3_op, .s3_rd, .s3_opr_a, .s3_opr_b, .s3_alu_res
    );

    frv_pipeline_multiply i_multiply (
        .g_clk, .arst_n,
        .s3_valid, .s3_op, .s3_rd, .s3_opr_a, .s3_opr_b, .s3_alu_res,
        .fwd_s3 (fwd_s3.producer),
        .fwd_s4 (fwd_s4.producer)
    );

    frv_gprs i_gprs (
        .g_clk, .arst_n,
        .rs1_addr    (s1_rs1_addr),
        .rs2_addr    (s1_rs2_addr),
        .rs3_addr    (s1_rs3_addr),
        .rs1_data    (gpr_rs1_data),
        .rs2_data    (gpr_rs2_data),
        .rs3_data    (gpr_rs3_data),
        .rd_wen      (fwd_s4.valid),           // rd x0 covers undefined opcodes
        .rd_wide     (fwd_s4.wide),
        .rd_addr     (fwd_s4.rd),
        .rd_wdata    (fwd_s4.wdata),
        .rd_wdata_hi (fwd_s4.wdata_hi)
    );

    // Retire trace
    // ----------------------------------------
    assign trs_valid    = fwd_s4.valid;
    assign trs_rd       = fwd_s4.rd;
    assign trs_wide     = fwd_s4.wide;
    assign trs_wdata    = fwd_s4.wdata;
    assign trs_wdata_hi = fwd_s4.wdata_hi;

endmodule : frv_pipeline

// File: dv/frv_pipeline_model.svh
/*
 Reference register model, LFSR and compare tasks for the pipeline testbench.
 Included inside the testbench module and uses its trace signals and test state.
 The model executes each retired word in acceptance order on its own registers.
*/
`ifndef FRV_PIPELINE_MODEL_SVH
`define FRV_PIPELINE_MODEL_SVH

int          errors = 0;                       // Failed checks, all tests
int          checks = 0;
xlen_t       model_regs [32] = '{default: '0}; // x0 kept at zero
logic [15:0] lfsr_state = 16'd87;              // Fixed seed

// Random bits
// ----------------------------------------
// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        v          = {v[30:0], fb};
    end
    return v;
endfunction

// Compare tasks
// ----------------------------------------
task automatic compare_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
    checks++;
    if (act !== exp) begin
        $display("Error %s rd: expected x%0d, actual x%0d", name, exp, act);
        errors++;
    end
endtask

task automatic compare_word(input string name, input xlen_t exp, input xlen_t act);
    checks++;
    if (act !== exp) begin
        $display("Error %s data: expected %h, actual %h", name, exp, act);
        errors++;
    end
endtask

task automatic compare_wide(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        $display("Error %s wide: expected %b, actual %b", name, exp, act);
        errors++;
    end
endtask

task automatic compare_latency(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
        $display("Error %s latency: expected %0d, actual %0d", name, exp, act);
        errors++;
    end
endtask

// Sequential execution of one retired word
// ----------------------------------------
task automatic retire_check(input instr_t w, input time acc_t);
    reg_addr_t   rd;
    xlen_t       a, b, c, lo, hi;
    logic [63:0] prod;
    logic        wide;
    logic        known;
    a     = model_regs[w.r.rs1];
    b     = model_regs[w.r.rs2];
    c     = model_regs[w.r.rs3];
    rd    = w.r.rd;
    prod  = {32'b0, a} * {32'b0, b};           // Unsigned 64-bit product
    lo    = '0;
    hi    = prod[63:32];
    wide  = 1'b0;
    known = 1'b1;
    case (w.r.opcode)
        OP_ADD:  lo = a + b;
        OP_SUB:  lo = a - b;
        OP_XOR:  lo = a ^ b;
        OP_ADDI: lo = a + {{(XLEN-IMM_W){w.i.imm[IMM_W-1]}}, w.i.imm};
        OP_ADD3: lo = a + b + c;
        OP_MUL:  lo = prod[31:0];
        OP_MULW: begin
            lo   = prod[31:0];
            wide = 1'b1;
            rd   = {w.r.rd[4:1], 1'b0};        // Pair base is even
        end
        default: begin
            rd    = '0;                        // Undefined, no write
            known = 1'b0;
        end
    endcase
    compare_rd(cur_test, rd, trs_rd);
    compare_wide(cur_test, wide, trs_wide);
    if (known) compare_word(cur_test, lo, trs_wdata);
    if (wide) compare_word(cur_test, hi, trs_wdata_hi);
    if (lat_check) compare_latency(cur_test, 4, int'(($time - acc_t + 2) / 4));
    if (known) model_regs[rd] = lo;
    if (wide) model_regs[{rd[4:1], 1'b1}] = hi;
    model_regs[0] = '0;                        // x0 writes dropped
endtask

`endif

// File: dv/frv_pipeline_tb.sv
/*
 Random stimulus from a fixed LFSR seed, checked against a register model.
 Inputs change 1 ns after the rising edge and outputs are sampled on the falling edge.
 Each test drains the pipeline before the next one starts.
*/
`timescale 1ns/10ps

module frv_pipeline_tb import frv_core_pkg::*, frv_isa_pkg::*; ();

    localparam int N_RESET = 8;                // Instructions per test
    localparam int N_ALU   = 60;
    localparam int N_MUL   = 60;
    localparam int N_PAIR  = 40;
    localparam int N_X0    = 40;
    localparam int N_LAT   = 20;
    localparam int TIMEOUT = 2 * (N_RESET + N_ALU + N_MUL + N_PAIR + N_X0 + N_LAT) + 40;

    localparam int MIX_ALU  = 0;               // Stimulus mixes
    localparam int MIX_MUL  = 1;
    localparam int MIX_PAIR = 2;
    localparam int MIX_X0   = 3;

    localparam opcode_t ALU_OPS [8] = '{OP_ADD, OP_SUB, OP_XOR, OP_ADDI,
                                        OP_ADD3, OP_ADD, OP_XOR, OP_ADD3};

    logic        g_clk = 1'b0;
    logic        arst_n;
    logic        instr_valid;
    logic [31:0] instr_word;
    logic        instr_busy;
    logic        trs_valid;
    reg_addr_t   trs_rd;
    logic        trs_wide;
    xlen_t       trs_wdata;
    xlen_t       trs_wdata_hi;

    instr_t accept_q [$];                      // Accepted but not yet retired
    time    acc_t_q [$];                       // Accepting edge times
    string  cur_test    = "reset_state";
    logic   lat_check   = 1'b0;                // Check retire latency
    logic   busy_banned = 1'b1;                // No multiplies in stream
    int     cycles      = 0;

    `include "frv_pipeline_model.svh"

    frv_pipeline frv_pipeline_i (.*);

    always #2 g_clk = ~g_clk;                  // 4 ns period

    // Timeout
    always @(posedge g_clk) begin
        if (arst_n) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timeout: run did not end within %0d cycles", TIMEOUT);
                $display("STATUS: FAIL");
                $finish;
            end
        end
    end

    // Retire monitor
    // ----------------------------------------
    always @(negedge g_clk) begin
        if (arst_n && trs_valid) begin
            if (accept_q.size() == 0) begin
                $display("%s: retired an instruction that was never accepted", cur_test);
                errors++;
            end else begin
                retire_check(accept_q.pop_front(), acc_t_q.pop_front());
            end
        end
    end

    function automatic instr_t make_instr(input int mix);
        instr_t      w;
        logic [31:0] v;
        w = '0;
        v = rand_bits(3);
        w.r.opcode = ALU_OPS[v[2:0]];
        if (mix == MIX_MUL) begin
            v = rand_bits(2);
            if (v[1:0] == 2'b00) w.r.opcode = OP_MUL;
            if (v[1:0] == 2'b01) w.r.opcode = OP_MULW;
        end else if (mix == MIX_PAIR) begin
            v = rand_bits(1);
            if (v[0]) w.r.opcode = OP_MULW;    // Half the stream writes pairs
        end else if (mix == MIX_X0) begin
            v = rand_bits(5);
            if (v[4:3] == 2'b00) w.r.opcode = opcode_t'(4'h7 + {1'b0, v[2:0]});  // Undefined
        end
        v = rand_bits((mix == MIX_X0) ? 2 : 3);
        w.r.rd = (mix == MIX_X0) ? {3'b000, v[1:0]} : {2'b00, v[2:0]};  // Small register set
        v = rand_bits(9);
        w.r.rs1 = {2'b00, v[2:0]};
        w.r.rs2 = {2'b00, v[5:3]};
        w.r.rs3 = {2'b00, v[8:6]};
        if (w.r.opcode == OP_ADDI) begin
            v = rand_bits(IMM_W);
            w.i.imm = v[IMM_W-1:0];            // Covers the rs2 and rs3 bits
        end
        return w;
    endfunction

    // Stimulus
    // ----------------------------------------
    task automatic issue(input instr_t w);
        instr_valid = 1'b1;
        instr_word  = w;
        @(negedge g_clk);
        while (instr_busy) begin               // Held steady while busy
            if (busy_banned) begin
                $display("%s: instr_busy rose in a stream without multiplies", cur_test);
                errors++;
            end
            @(negedge g_clk);
        end
        @(posedge g_clk);                      // Accepting edge
        accept_q.push_back(w);
        acc_t_q.push_back($time);
        #1;
    endtask

    task automatic idle_cycle();
        instr_valid = 1'b0;
        @(posedge g_clk);
        #1;
    endtask

    task automatic run_test(input string name, input int count, input int mix,
                            input logic gaps);
        int          err0;
        logic [31:0] g;
        cur_test = name;
        err0     = errors;
        for (int n = 0; n < count; n++) begin
            if (gaps) begin
                g = rand_bits(2);
                if (g[1:0] == 2'b00) idle_cycle();
            end
            issue(make_instr(mix));
        end
        instr_valid = 1'b0;
        while (accept_q.size() != 0) @(posedge g_clk);   // Drain
        #1;
        $display("test %s: %0d instructions, %0d errors", name, count, errors - err0);
    endtask

    initial begin
        instr_valid = 1'b0;
        instr_word  = '0;
        arst_n      = 1'b0;
        repeat (5) @(posedge g_clk);
        #1 arst_n = 1'b1;
        @(negedge g_clk);
        if (trs_valid || instr_busy) begin
            $display("reset_state: trs_valid or instr_busy high after reset");
            errors++;
        end
        @(posedge g_clk);
        #1;
        run_test("reset_state", N_RESET, MIX_ALU, 1'b0);
        run_test("alu_forward", N_ALU, MIX_ALU, 1'b0);
        busy_banned = 1'b0;
        run_test("mul_bubble", N_MUL, MIX_MUL, 1'b1);
        run_test("reg_pair", N_PAIR, MIX_PAIR, 1'b1);
        run_test("x0_undefined", N_X0, MIX_X0, 1'b1);
        busy_banned = 1'b1;
        lat_check   = 1'b1;
        run_test("latency", N_LAT, MIX_ALU, 1'b0);
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : frv_pipeline_tb

// File: all.f
+incdir+dv
source/frv_core_pkg.sv
source/frv_isa_pkg.sv
source/frv_fwd_if.sv
source/frv_gprs.sv
source/frv_hazard_unit.sv
source/frv_pipeline_decode.sv
source/frv_pipeline_execute.sv
source/frv_pipeline_multiply.sv
source/frv_pipeline.sv
dv/frv_pipeline_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert -j 0 --top-module frv_pipeline_tb \
		-Mdir obj_dir -f all.f
	@out="$$(./obj_dir/Vfrv_pipeline_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
